// File: openadc_ctrl.f
source/openadc_pkg.sv
source/openadc_regs.sv
source/trigger_unit.sv
source/capture_channel.sv
source/capture_readout.sv
source/openadc_top.sv
verif/openadc_assertions.sv
verif/openadc_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the openadc_ctrl testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f openadc_ctrl.f \
   --top-module openadc_tb \
   -o openadc_sim &&
./obj_dir/openadc_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

// File: verif/openadc_tb.sv
`timescale 1ns/1ps

module openadc_tb;

   localparam int NUM_CH     = 4;
   localparam int DEPTH_W    = 6;
   localparam int BYTECNT_W  = 7;
   localparam int DEPTH      = 1 << DEPTH_W;
   localparam int SW         = openadc_pkg::SAMPLE_W;
   localparam int POLL_LIMIT = 400;
   // per test at most a decimate 2 capture plus a full readout and bus traffic
   localparam int TEST_CYCLES     = 6 * (DEPTH * 3 + NUM_CH * DEPTH + 100);
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;
   localparam logic [7:0] ARM_MASK = 8'(1 << openadc_pkg::SET_ARM_BIT);

   logic                 clk_usb;
   logic                 reset;
   logic [7:0]           reg_address_i;
   logic [BYTECNT_W-1:0] reg_bytecnt_i;
   logic [7:0]           reg_data_i;
   logic                 reg_read_i;
   logic                 reg_write_i;
   logic                 trigger_i;
   logic [NUM_CH*SW-1:0] adc_data_i;
   logic [7:0]           reg_data_o;
   logic                 capture_start_o;

   int unsigned cycle = 0;
   int unsigned start_cyc;
   logic        start_seen;
   logic [31:0] act_q[$];
   logic [31:0] exp_q[$];
   string       name_q[$];

   openadc_top #(
      .pNUM_CH       (NUM_CH),
      .pDEPTH_W      (DEPTH_W),
      .pBYTECNT_SIZE (BYTECNT_W)
   ) openadc_top_i (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .reg_data_i      (reg_data_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .trigger_i       (trigger_i),
      .adc_data_i      (adc_data_i),
      .reg_data_o      (reg_data_o),
      .capture_start_o (capture_start_o)
   );

   initial begin
      clk_usb = 1'b0;
      forever #5 clk_usb = ~clk_usb;
   end

   // ramp per channel with 16 codes between channels
   always @(posedge clk_usb) begin
      #1;
      cycle = cycle + 1;
      for (int k = 0; k < NUM_CH; k++) begin
         adc_data_i[k*SW +: SW] = 8'((cycle + 16 * k) % 256);
      end
   end

   always @(negedge clk_usb) begin
      if (capture_start_o) begin
         start_cyc  = cycle;  // ramp cycle of the start pulse
         start_seen = 1'b1;
      end
   end

   always @(negedge clk_usb) begin
      while (act_q.size() > 0) begin
         check_value(name_q.pop_front(), act_q.pop_front(), exp_q.pop_front());
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_usb);
      $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $fatal(1, "run did not finish in time");
   end

   // first sample is the one present in the cycle after the pulse
   function automatic logic [7:0] expected_sample(input int unsigned start, input int unsigned dec,
                                                  input int ch, input int idx);
      int unsigned at_cycle;
      at_cycle = start + 1 + idx * (dec + 1);
      return 8'((at_cycle + 16 * ch) % 256);
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
         $display("Some tests failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic bus_write(input logic [7:0] addr, input int lane, input logic [7:0] data);
      reg_address_i = addr;
      reg_bytecnt_i = BYTECNT_W'(lane);
      reg_data_i    = data;
      reg_write_i   = 1'b1;
      @(posedge clk_usb);
      #1;
      reg_write_i = 1'b0;
   endtask

   task automatic write_word(input logic [7:0] addr, input int nbytes, input logic [31:0] value);
      for (int i = 0; i < nbytes; i++) begin
         bus_write(addr, i, value[i*8 +: 8]);
      end
   endtask

   task automatic bus_read(input logic [7:0] addr, input int lane, output logic [7:0] data);
      reg_address_i = addr;
      reg_bytecnt_i = BYTECNT_W'(lane);
      reg_read_i    = 1'b1;
      @(posedge clk_usb);
      #1;
      reg_read_i = 1'b0;
      data       = reg_data_o;  // registered at the edge just passed
   endtask

   task automatic expect_read(input logic [7:0] addr, input int lane, input logic [7:0] expected,
                              input string name);
      logic [7:0] data;
      bus_read(addr, lane, data);
      act_q.push_back({24'h0, data});
      exp_q.push_back({24'h0, expected});
      name_q.push_back(name);
   endtask

   task automatic expect_word(input logic [7:0] addr, input int nbytes, input logic [31:0] value,
                              input string name);
      for (int i = 0; i < nbytes; i++) begin
         expect_read(addr, i, value[i*8 +: 8], $sformatf("%s byte %0d", name, i));
      end
   endtask

   task automatic arm_capture(input logic [7:0] settings);
      bus_write(openadc_pkg::SETTINGS, 0, settings & ~ARM_MASK);  // arm low so it sees an edge
      start_seen = 1'b0;
      bus_write(openadc_pkg::SETTINGS, 0, settings | ARM_MASK);
      @(posedge clk_usb);
      #1;
   endtask

   task automatic wait_for_start();
      int n;
      n = 0;
      while (!start_seen && n < POLL_LIMIT) begin
         @(posedge clk_usb);
         #1;
         n++;
      end
      if (!start_seen) begin
         $display("Timeout: capture_start never pulsed after arming");
         $display("Some tests failed");
         $fatal(1, "no capture start");
      end
   endtask

   task automatic wait_for_done();
      logic [7:0] status;
      int n;
      n = 0;
      status = 8'h00;
      while (!(status[openadc_pkg::STAT_DONE_BIT] && !status[openadc_pkg::STAT_BUSY_BIT])
             && n < POLL_LIMIT) begin
         bus_read(openadc_pkg::STATUS, 0, status);
         n++;
      end
      if (!(status[openadc_pkg::STAT_DONE_BIT] && !status[openadc_pkg::STAT_BUSY_BIT])) begin
         $display("Timeout: STATUS never showed done with busy clear");
         $display("Some tests failed");
         $fatal(1, "capture did not finish");
      end
   endtask

   task automatic check_capture(input int unsigned dec, input int nsamp, input string tag);
      for (int k = 0; k < NUM_CH; k++) begin
         bus_write(openadc_pkg::CHANNEL_SEL, 0, 8'(k));  // also clears the pointer
         for (int i = 0; i < nsamp; i++) begin
            expect_read(openadc_pkg::FIFO_DATA, 0, expected_sample(start_cyc, dec, k, i),
                        $sformatf("fifo_data %s ch%0d sample %0d", tag, k, i));
         end
      end
   endtask

   initial begin
      logic [7:0]  val;
      logic [31:0] word;
      int          nsamp;
      int          len;
      void'($urandom(44608));
      reset         = 1'b1;
      reg_address_i = 8'h00;
      reg_bytecnt_i = '0;
      reg_data_i    = 8'h00;
      reg_read_i    = 1'b0;
      reg_write_i   = 1'b0;
      trigger_i     = 1'b0;
      adc_data_i    = '0;
      start_seen    = 1'b0;
      repeat (8) @(posedge clk_usb);
      #1;
      reset = 1'b0;
      @(posedge clk_usb);
      #1;

      // reset values and echo
      expect_read(openadc_pkg::SETTINGS, 0, 8'h04, "settings");
      expect_read(openadc_pkg::STATUS, 0, 8'h00, "status");
      expect_word(openadc_pkg::VERSION, 2, {16'h0, openadc_pkg::VERSION_VALUE}, "version");
      repeat (4) begin
         val = 8'($urandom);
         bus_write(openadc_pkg::ECHO, 0, val);
         expect_read(openadc_pkg::ECHO, 0, val, "echo");
      end

      // multi-byte registers
      word = $urandom;
      write_word(openadc_pkg::OFFSET, 4, word);
      expect_word(openadc_pkg::OFFSET, 4, word, "offset");
      word = $urandom;
      write_word(openadc_pkg::DECIMATE, 2, word);
      expect_word(openadc_pkg::DECIMATE, 2, word, "decimate");
      word = $urandom;
      write_word(openadc_pkg::SAMPLES, 2, word);
      expect_word(openadc_pkg::SAMPLES, 2, word, "samples");

      // rising edge with decimate 0 and a small random offset
      nsamp = 1 + int'($urandom % DEPTH);
      write_word(openadc_pkg::DECIMATE, 2, 32'd0);
      write_word(openadc_pkg::SAMPLES, 2, nsamp);
      write_word(openadc_pkg::OFFSET, 4, $urandom % 8);
      arm_capture(8'h04);
      expect_read(openadc_pkg::STATUS, 0, 8'h01, "status armed");
      trigger_i = 1'b1;
      wait_for_start();
      wait_for_done();
      check_capture(0, nsamp, "rising");

      // falling edge with decimate 2
      nsamp = 1 + int'($urandom % DEPTH);
      write_word(openadc_pkg::DECIMATE, 2, 32'd2);
      write_word(openadc_pkg::SAMPLES, 2, nsamp);
      write_word(openadc_pkg::OFFSET, 4, 32'd0);
      arm_capture(8'h00);
      trigger_i = 1'b0;
      wait_for_start();
      wait_for_done();
      check_capture(2, nsamp, "falling");

      // trigger held active for len cycles
      len = 3 + int'($urandom % 30);
      write_word(openadc_pkg::DECIMATE, 2, 32'd0);
      write_word(openadc_pkg::SAMPLES, 2, 32'd8);
      arm_capture(8'h04);
      trigger_i = 1'b1;
      repeat (len) @(posedge clk_usb);
      #1;
      trigger_i = 1'b0;
      wait_for_start();
      wait_for_done();
      expect_word(openadc_pkg::TRIGGER_DUR, 4, len, "trigger_dur");
      check_capture(0, 8, "duration");

      // forced trigger while the pin stays low
      arm_capture(8'h44);
      wait_for_start();
      wait_for_done();
      expect_word(openadc_pkg::TRIGGER_DUR, 4, 32'd0, "trigger_dur forced");
      check_capture(0, 8, "forced");

      // soft reset restores defaults
      write_word(openadc_pkg::OFFSET, 4, $urandom | 32'h1);
      bus_write(openadc_pkg::SOFT_RESET, 0, 8'h01);
      bus_write(openadc_pkg::SOFT_RESET, 0, 8'h00);
      expect_read(openadc_pkg::SETTINGS, 0, 8'h04, "settings after soft reset");
      expect_word(openadc_pkg::OFFSET, 4, 32'd0, "offset after soft reset");
      expect_read(openadc_pkg::STATUS, 0, 8'h00, "status after soft reset");

      repeat (2) @(posedge clk_usb);  // lets the compare process drain the last read
      $display("All tests passed");
      $finish;
   end

endmodule

// File: verif/openadc_assertions.sv
`timescale 1ns/1ps

module openadc_assertions #(
   parameter int pDEPTH_W = 6
) (
   input logic                clk_usb,
   input logic                reset_i,
   input logic                reg_read_i,
   input logic [7:0]          reg_data_i,
   input logic                capture_start_i,
   input logic                busy_i,
   input logic                fifo_rd_i,
   input logic                chan_clear_i,
   input logic [pDEPTH_W-1:0] rd_addr_i
);

   property idle_bus_zero;
      @(posedge clk_usb) disable iff (reset_i)
         !reg_read_i |=> (reg_data_i == 8'h00);  // idle bus returns zero
   endproperty

   property start_single_cycle;
      @(posedge clk_usb) disable iff (reset_i)
         capture_start_i |=> !capture_start_i;
   endproperty

   property start_while_busy;
      @(posedge clk_usb) disable iff (reset_i)
         capture_start_i |-> busy_i;
   endproperty

   // read pointer only moves on a FIFO_DATA read or a channel select
   property pointer_holds;
      @(posedge clk_usb) disable iff (reset_i)
         (!fifo_rd_i && !chan_clear_i) |=> $stable(rd_addr_i);
   endproperty

   assert property (idle_bus_zero)
      else $error("reg_data_o not zero after a cycle without a read");
   assert property (start_single_cycle)
      else $error("capture_start_o held for more than one cycle");
   assert property (start_while_busy)
      else $error("capture_start_o pulsed while the trigger unit was not busy");
   assert property (pointer_holds)
      else $error("FIFO read pointer moved without a read or channel select");

endmodule

bind openadc_top openadc_assertions #(
   .pDEPTH_W (pDEPTH_W)
) openadc_assertions_i (
   .clk_usb         (clk_usb),
   .reset_i         (sys_reset),
   .reg_read_i      (reg_read_i),
   .reg_data_i      (reg_data_o),
   .capture_start_i (capture_start_o),
   .busy_i          (busy),
   .fifo_rd_i       (fifo_rd),
   .chan_clear_i    (chan_clear),
   .rd_addr_i       (rd_addr)
);

// File: source/openadc_top.sv
`timescale 1ns/1ps

module openadc_top #(
   parameter int pNUM_CH       = 4,
   parameter int pDEPTH_W      = 6,
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                                     clk_usb,
   input  logic                                     reset,
   input  logic [7:0]                               reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0]                 reg_bytecnt_i,
   input  logic [7:0]                               reg_data_i,
   input  logic                                     reg_read_i,
   input  logic                                     reg_write_i,
   input  logic                                     trigger_i,
   input  logic [pNUM_CH*openadc_pkg::SAMPLE_W-1:0] adc_data_i,
   output logic [7:0]                               reg_data_o,
   output logic                                     capture_start_o
);

   localparam int SW = openadc_pkg::SAMPLE_W;

   logic                    sys_reset;  // pin reset or soft reset
   logic                    arm;
   logic                    trig_rising;
   logic                    trig_now;
   logic [31:0]             offset;
   logic [15:0]             decimate;
   logic [15:0]             samples;
   logic [7:0]              chan_sel;
   logic                    fifo_rd;
   logic                    chan_clear;
   logic                    armed;
   logic                    busy;
   logic [31:0]             trig_duration;
   logic                    all_done;
   logic [SW-1:0]           fifo_data;
   logic [pDEPTH_W-1:0]     rd_addr;
   logic [pNUM_CH*SW-1:0]   chan_data;
   logic [pNUM_CH-1:0]      chan_done;

   openadc_regs #(
      .pBYTECNT_SIZE (pBYTECNT_SIZE)
   ) openadc_regs_i (
      .clk_usb         (clk_usb),
      .reset_i         (reset),
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .reg_data_i      (reg_data_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .armed_i         (armed),
      .busy_i          (busy),
      .all_done_i      (all_done),
      .trig_duration_i (trig_duration),
      .fifo_data_i     (fifo_data),
      .reg_data_o      (reg_data_o),
      .reset_o         (sys_reset),
      .arm_o           (arm),
      .trig_rising_o   (trig_rising),
      .trig_now_o      (trig_now),
      .offset_o        (offset),
      .decimate_o      (decimate),
      .samples_o       (samples),
      .chan_sel_o      (chan_sel),
      .fifo_rd_o       (fifo_rd),
      .chan_clear_o    (chan_clear)
   );

   trigger_unit trigger_unit_i (
      .clk_usb         (clk_usb),
      .reset_i         (sys_reset),
      .trigger_i       (trigger_i),
      .arm_i           (arm),
      .trig_rising_i   (trig_rising),
      .trig_now_i      (trig_now),
      .offset_i        (offset),
      .all_done_i      (all_done),
      .armed_o         (armed),
      .busy_o          (busy),
      .capture_start_o (capture_start_o),
      .trig_duration_o (trig_duration)
   );

   for (genvar g = 0; g < pNUM_CH; g++) begin : gen_ch
      capture_channel #(
         .pDEPTH_W (pDEPTH_W)
      ) capture_channel_i (
         .clk_usb         (clk_usb),
         .reset_i         (sys_reset),
         .adc_data_i      (adc_data_i[g*SW +: SW]),
         .capture_start_i (capture_start_o),
         .decimate_i      (decimate),
         .samples_i       (samples),
         .rd_addr_i       (rd_addr),
         .rd_data_o       (chan_data[g*SW +: SW]),
         .done_o          (chan_done[g])
      );
   end

   capture_readout #(
      .pNUM_CH  (pNUM_CH),
      .pDEPTH_W (pDEPTH_W)
   ) capture_readout_i (
      .clk_usb      (clk_usb),
      .reset_i      (sys_reset),
      .chan_sel_i   (chan_sel),
      .chan_clear_i (chan_clear),
      .fifo_rd_i    (fifo_rd),
      .chan_data_i  (chan_data),
      .chan_done_i  (chan_done),
      .rd_addr_o    (rd_addr),
      .fifo_data_o  (fifo_data),
      .all_done_o   (all_done)
   );

endmodule

// File: source/capture_readout.sv
`timescale 1ns/1ps

module capture_readout #(
   parameter int pNUM_CH  = 4,
   parameter int pDEPTH_W = 6
) (
   input  logic                                     clk_usb,
   input  logic                                     reset_i,
   input  logic [7:0]                               chan_sel_i,
   input  logic                                     chan_clear_i,
   input  logic                                     fifo_rd_i,
   input  logic [pNUM_CH*openadc_pkg::SAMPLE_W-1:0] chan_data_i,
   input  logic [pNUM_CH-1:0]                       chan_done_i,
   output logic [pDEPTH_W-1:0]                      rd_addr_o,
   output logic [openadc_pkg::SAMPLE_W-1:0]         fifo_data_o,
   output logic                                     all_done_o
);

   localparam int SW = openadc_pkg::SAMPLE_W;

   // one pointer shared by all channel stores
   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         rd_addr_o <= '0;
      end else if (chan_clear_i) begin
         rd_addr_o <= '0;  // new channel selected
      end else if (fifo_rd_i) begin
         rd_addr_o <= rd_addr_o + 1'b1;  // wraps at store depth
      end
   end

   always_comb begin
      fifo_data_o = '0;  // out of range channel reads zero
      for (int k = 0; k < pNUM_CH; k++) begin
         if (chan_sel_i == k) begin
            fifo_data_o = chan_data_i[k*SW +: SW];
         end
      end
   end

   assign all_done_o = &chan_done_i;

endmodule

// File: source/capture_channel.sv
`timescale 1ns/1ps

module capture_channel #(
   parameter int pDEPTH_W = 6
) (
   input  logic                             clk_usb,
   input  logic                             reset_i,
   input  logic [openadc_pkg::SAMPLE_W-1:0] adc_data_i,
   input  logic                             capture_start_i,
   input  logic [15:0]                      decimate_i,
   input  logic [15:0]                      samples_i,
   input  logic [pDEPTH_W-1:0]              rd_addr_i,
   output logic [openadc_pkg::SAMPLE_W-1:0] rd_data_o,
   output logic                             done_o
);

   localparam logic [pDEPTH_W:0] DEPTH = {1'b1, {pDEPTH_W{1'b0}}};

   logic [openadc_pkg::SAMPLE_W-1:0] mem [0:(1 << pDEPTH_W)-1];

   logic                active;
   logic [15:0]         dec_cnt;
   logic [pDEPTH_W:0]   cnt;
   logic [pDEPTH_W:0]   target;
   logic [pDEPTH_W:0]   target_next;
   logic                store;

   assign target_next = (samples_i > 16'(DEPTH)) ? DEPTH : samples_i[pDEPTH_W:0];
   assign store       = active && (dec_cnt == 16'd0);  // one in decimate+1 cycles

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         active  <= 1'b0;
         done_o  <= 1'b0;
         dec_cnt <= 16'd0;
         cnt     <= '0;
         target  <= '0;
      end else if (capture_start_i) begin
         active  <= (samples_i != 16'd0);
         done_o  <= (samples_i == 16'd0);  // nothing to take
         dec_cnt <= 16'd0;
         cnt     <= '0;
         target  <= target_next;
      end else if (active) begin
         dec_cnt <= (dec_cnt == decimate_i) ? 16'd0 : dec_cnt + 16'd1;
         if (store) begin
            cnt <= cnt + 1'b1;
            if (cnt + 1'b1 == target) begin
               active <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (store) begin
         mem[cnt[pDEPTH_W-1:0]] <= adc_data_i;
      end
   end

   assign rd_data_o = mem[rd_addr_i];  // async read for the readout mux

endmodule

// File: source/trigger_unit.sv
`timescale 1ns/1ps

module trigger_unit (
   input  logic        clk_usb,
   input  logic        reset_i,
   input  logic        trigger_i,
   input  logic        arm_i,
   input  logic        trig_rising_i,
   input  logic        trig_now_i,
   input  logic [31:0] offset_i,
   input  logic        all_done_i,
   output logic        armed_o,
   output logic        busy_o,
   output logic        capture_start_o,
   output logic [31:0] trig_duration_o
);

   openadc_pkg::trig_state_e state;

   logic        trig_q;
   logic        trig_q2;
   logic        arm_q;
   logic [31:0] delay_cnt;
   logic        measuring;
   logic        trig_active;
   logic        trig_edge;
   logic        fire;

   assign trig_active = (trig_q == trig_rising_i);  // active level follows edge select
   assign trig_edge   = trig_rising_i ? (trig_q & ~trig_q2) : (~trig_q & trig_q2);
   assign fire        = (state == openadc_pkg::ARMED) && (trig_now_i || trig_edge);

   assign armed_o = (state == openadc_pkg::ARMED);
   assign busy_o  = (state == openadc_pkg::DELAY) || (state == openadc_pkg::CAPTURE);

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         trig_q  <= 1'b0;
         trig_q2 <= 1'b0;
         arm_q   <= 1'b0;
      end else begin
         trig_q  <= trigger_i;
         trig_q2 <= trig_q;
         arm_q   <= arm_i;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         state           <= openadc_pkg::IDLE;
         delay_cnt       <= 32'd0;
         capture_start_o <= 1'b0;
      end else begin
         capture_start_o <= 1'b0;
         case (state)
            openadc_pkg::IDLE: begin
               if (arm_i && !arm_q) state <= openadc_pkg::ARMED;  // arm rising edge
            end
            openadc_pkg::ARMED: begin
               if (fire) begin
                  state     <= openadc_pkg::DELAY;
                  delay_cnt <= 32'd0;
               end
            end
            openadc_pkg::DELAY: begin
               if (delay_cnt == offset_i) begin
                  capture_start_o <= 1'b1;
                  state           <= openadc_pkg::CAPTURE;
               end else begin
                  delay_cnt <= delay_cnt + 32'd1;
               end
            end
            openadc_pkg::CAPTURE: begin
               // done flags still hold the last run during the start pulse
               if (all_done_i && !capture_start_o) state <= openadc_pkg::IDLE;
            end
            default: state <= openadc_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         trig_duration_o <= 32'd0;
         measuring       <= 1'b0;
      end else if (fire) begin
         trig_duration_o <= {31'd0, trig_active};
         measuring       <= trig_active;
      end else if (measuring) begin
         if (trig_active) trig_duration_o <= trig_duration_o + 32'd1;
         else             measuring <= 1'b0;  // freeze at first inactive cycle
      end
   end

endmodule

// File: source/openadc_regs.sv
`timescale 1ns/1ps

module openadc_regs #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                             clk_usb,
   input  logic                             reset_i,
   input  logic [7:0]                       reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0]         reg_bytecnt_i,
   input  logic [7:0]                       reg_data_i,
   input  logic                             reg_read_i,
   input  logic                             reg_write_i,
   input  logic                             armed_i,
   input  logic                             busy_i,
   input  logic                             all_done_i,
   input  logic [31:0]                      trig_duration_i,
   input  logic [openadc_pkg::SAMPLE_W-1:0] fifo_data_i,
   output logic [7:0]                       reg_data_o,
   output logic                             reset_o,
   output logic                             arm_o,
   output logic                             trig_rising_o,
   output logic                             trig_now_o,
   output logic [31:0]                      offset_o,
   output logic [15:0]                      decimate_o,
   output logic [15:0]                      samples_o,
   output logic [7:0]                       chan_sel_o,
   output logic                             fifo_rd_o,
   output logic                             chan_clear_o
);

   logic [7:0]  settings_r;
   logic [7:0]  echo_r;
   logic [7:0]  chan_sel_r;
   logic [15:0] decimate_r;
   logic [15:0] samples_r;
   logic [31:0] offset_r;
   logic        soft_reset_r;
   logic [7:0]  status_w;

   // picks one byte lane of a word and gives zero beyond lane 3
   function automatic logic [7:0] lane_of(input logic [31:0]              word,
                                          input logic [pBYTECNT_SIZE-1:0] idx);
      logic [7:0] res;
      res = 8'h00;
      if (idx < 4) begin
         res = word[idx[1:0]*8 +: 8];
      end
      return res;
   endfunction

   assign reset_o = reset_i | soft_reset_r;

   assign arm_o         = settings_r[openadc_pkg::SET_ARM_BIT];
   assign trig_rising_o = settings_r[openadc_pkg::SET_TRIG_RISING_BIT];
   assign trig_now_o    = settings_r[openadc_pkg::SET_TRIG_NOW_BIT];
   assign offset_o      = offset_r;
   assign decimate_o    = decimate_r;
   assign samples_o     = samples_r;
   assign chan_sel_o    = chan_sel_r;

   // readout strobes in the same cycle as the bus access
   assign fifo_rd_o    = reg_read_i && (reg_address_i == openadc_pkg::FIFO_DATA);
   assign chan_clear_o = reg_write_i && (reg_address_i == openadc_pkg::CHANNEL_SEL);

   always_comb begin
      status_w = 8'h00;
      status_w[openadc_pkg::STAT_ARMED_BIT] = armed_i;
      status_w[openadc_pkg::STAT_BUSY_BIT]  = busy_i;
      status_w[openadc_pkg::STAT_DONE_BIT]  = all_done_i;
   end

   always_ff @(posedge clk_usb) begin
      if (reset_o) begin
         settings_r <= openadc_pkg::SETTINGS_DEFAULT;
         echo_r     <= 8'h00;
         chan_sel_r <= 8'h00;
         decimate_r <= openadc_pkg::DECIMATE_DEFAULT;
         samples_r  <= openadc_pkg::SAMPLES_DEFAULT;
         offset_r   <= openadc_pkg::OFFSET_DEFAULT;
      end else if (reg_write_i) begin
         case (reg_address_i)
            openadc_pkg::SETTINGS:    settings_r <= reg_data_i;
            openadc_pkg::ECHO:        echo_r     <= reg_data_i;
            openadc_pkg::CHANNEL_SEL: chan_sel_r <= reg_data_i;
            openadc_pkg::DECIMATE: begin
               if (reg_bytecnt_i < 2) begin
                  decimate_r[reg_bytecnt_i[0]*8 +: 8] <= reg_data_i;
               end
            end
            openadc_pkg::SAMPLES: begin
               if (reg_bytecnt_i < 2) begin
                  samples_r[reg_bytecnt_i[0]*8 +: 8] <= reg_data_i;
               end
            end
            openadc_pkg::OFFSET: begin
               if (reg_bytecnt_i < 4) begin
                  offset_r[reg_bytecnt_i[1:0]*8 +: 8] <= reg_data_i;
               end
            end
            default: ;
         endcase
      end
   end

   // soft reset bit survives its own reset and only the pin clears it
   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         soft_reset_r <= 1'b0;
      end else if (reg_write_i && (reg_address_i == openadc_pkg::SOFT_RESET)) begin
         soft_reset_r <= reg_data_i[0];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset_o) begin
         reg_data_o <= 8'h00;
      end else if (reg_read_i) begin
         case (reg_address_i)
            openadc_pkg::SETTINGS:    reg_data_o <= settings_r;
            openadc_pkg::STATUS:      reg_data_o <= status_w;
            openadc_pkg::FIFO_DATA:   reg_data_o <= fifo_data_i;
            openadc_pkg::ECHO:        reg_data_o <= echo_r;
            openadc_pkg::VERSION:     reg_data_o <= lane_of({16'h0000, openadc_pkg::VERSION_VALUE},
                                                            reg_bytecnt_i);
            openadc_pkg::DECIMATE:    reg_data_o <= lane_of({16'h0000, decimate_r}, reg_bytecnt_i);
            openadc_pkg::SAMPLES:     reg_data_o <= lane_of({16'h0000, samples_r}, reg_bytecnt_i);
            openadc_pkg::TRIGGER_DUR: reg_data_o <= lane_of(trig_duration_i, reg_bytecnt_i);
            openadc_pkg::OFFSET:      reg_data_o <= lane_of(offset_r, reg_bytecnt_i);
            openadc_pkg::SOFT_RESET:  reg_data_o <= {7'b0, soft_reset_r};
            openadc_pkg::CHANNEL_SEL: reg_data_o <= chan_sel_r;
            default:                  reg_data_o <= 8'h00;
         endcase
      end else begin
         reg_data_o <= 8'h00;  // idle bus reads as zero
      end
   end

endmodule

// File: source/openadc_pkg.sv
package openadc_pkg;

   // host register map in byte addresses
   typedef enum logic [7:0] {
      SETTINGS    = 8'h01,
      STATUS      = 8'h02,
      FIFO_DATA   = 8'h03,
      ECHO        = 8'h04,
      VERSION     = 8'h06,
      DECIMATE    = 8'h0F,  // 2 bytes
      SAMPLES     = 8'h10,  // 2 bytes
      TRIGGER_DUR = 8'h14,  // 4 bytes
      OFFSET      = 8'h1A,  // 4 bytes
      SOFT_RESET  = 8'h1C,
      CHANNEL_SEL = 8'h30
   } reg_addr_e;

   typedef enum logic [1:0] {
      IDLE,
      ARMED,
      DELAY,
      CAPTURE
   } trig_state_e;

   // SETTINGS bit positions
   localparam int SET_TRIG_RISING_BIT = 2;
   localparam int SET_ARM_BIT         = 3;
   localparam int SET_TRIG_NOW_BIT    = 6;

   // STATUS bit positions
   localparam int STAT_ARMED_BIT = 0;
   localparam int STAT_BUSY_BIT  = 1;
   localparam int STAT_DONE_BIT  = 2;

   // values loaded by hard or soft reset
   localparam logic [7:0]  SETTINGS_DEFAULT = 8'h04;  // rising edge trigger
   localparam logic [15:0] DECIMATE_DEFAULT = 16'h0000;
   localparam logic [15:0] SAMPLES_DEFAULT  = 16'd64;
   localparam logic [31:0] OFFSET_DEFAULT   = 32'h0000_0000;

   localparam logic [15:0] VERSION_VALUE = 16'h0A13;  // read only

   localparam int SAMPLE_W = 8;

endpackage
